//--- design/icache_params.svh
// -------------------------------------------------------------------
// Instruction cache lookup sizing
// Address, line, set and index widths shared by the design
// -------------------------------------------------------------------

`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Fetch request fields
`define ICACHE_FETCH_AW 32
`define ICACHE_ID_WIDTH 4

// Line and array geometry
`define ICACHE_LINE_WIDTH 128
`define ICACHE_LINE_COUNT 16
`define ICACHE_SET_COUNT 2

// Address split: offset, index, set number
`define ICACHE_LINE_ALIGN 4
`define ICACHE_COUNT_ALIGN 4
`define ICACHE_SET_ALIGN 1

// Address bits above offset and index
`define ICACHE_TAG_WIDTH 24

`endif

//--- design/icache_pkg.sv
// -------------------------------------------------------------------
// Instruction cache lookup types
// Request, tag entry, refill, response and array command structs
// -------------------------------------------------------------------

`include "icache_params.svh"

package icache_pkg;

  // Lookup request from the fetch side
  typedef struct packed {
    logic [`ICACHE_FETCH_AW-1:0] addr;
    logic [`ICACHE_ID_WIDTH-1:0] id;
  } fetch_req_t;

  // One stored tag with its status bits
  typedef struct packed {
    logic                         valid;
    logic                         error;
    logic [`ICACHE_TAG_WIDTH-1:0] tag;
  } tag_entry_t;

  typedef logic [`ICACHE_LINE_WIDTH-1:0] line_t;

  // Refill write from the next level
  typedef struct packed {
    logic [`ICACHE_COUNT_ALIGN-1:0] index;
    logic [`ICACHE_SET_ALIGN-1:0]   cset;
    logic [`ICACHE_TAG_WIDTH-1:0]   tag;
    line_t                          line;
    logic                           error;
  } refill_t;

  // Lookup result returned to the fetch side
  typedef struct packed {
    logic [`ICACHE_FETCH_AW-1:0]  addr;
    logic [`ICACHE_ID_WIDTH-1:0]  id;
    logic [`ICACHE_SET_ALIGN-1:0] cset;
    logic                         hit;
    logic                         error;
    line_t                        line;
  } lookup_rsp_t;

  // Shared command to the tag and data arrays
  typedef struct packed {
    logic                           re;
    logic [`ICACHE_SET_COUNT-1:0]   wmask;
    logic [`ICACHE_COUNT_ALIGN-1:0] index;
  } array_port_t;

endpackage

//--- design/way_array.sv
// -------------------------------------------------------------------
// Set-associative way storage
// One bank per set, written by mask, read in parallel at one index
// -------------------------------------------------------------------

`timescale 1ns/1ps

`include "icache_params.svh"

module way_array #(
  parameter type payload_t = logic
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  icache_pkg::array_port_t               port_i,
  input  payload_t                              wdata_i,
  output payload_t [`ICACHE_SET_COUNT-1:0]      rdata_o
);

  // Storage, one bank per set
  payload_t mem_q [`ICACHE_SET_COUNT][`ICACHE_LINE_COUNT];

  // -----------------------------------------------------------------
  // Write port
  // -----------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    for (int s = 0; s < `ICACHE_SET_COUNT; s++) begin
      if (port_i.wmask[s]) begin
        mem_q[s][port_i.index] <= wdata_i;
      end
    end
  end

  // -----------------------------------------------------------------
  // Read port
  // -----------------------------------------------------------------
  // All sets are read together; the result holds until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (port_i.re) begin
      for (int s = 0; s < `ICACHE_SET_COUNT; s++) begin
        rdata_o[s] <= mem_q[s][port_i.index];
      end
    end
  end

endmodule

//--- design/lookup_ctrl.sv
// -------------------------------------------------------------------
// Lookup controller
// Invalidation sweep, flush, array port arbitration, lookup launch
// -------------------------------------------------------------------

`timescale 1ns/1ps

`include "icache_params.svh"

module lookup_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  icache_pkg::fetch_req_t  in_req_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  icache_pkg::refill_t     write_i,
  input  logic                    write_valid_i,
  output logic                    write_ready_o,
  input  logic                    flush_valid_i,
  output logic                    flush_ready_o,
  input  logic                    sel_ready_i,
  output icache_pkg::array_port_t port_o,
  output icache_pkg::tag_entry_t  tag_wdata_o,
  output icache_pkg::line_t       line_wdata_o,
  output logic                    launch_o,
  output icache_pkg::fetch_req_t  launch_req_o
);

  // Counter value once every index has been cleared
  localparam logic [`ICACHE_COUNT_ALIGN:0] sweep_end =
    (`ICACHE_COUNT_ALIGN + 1)'(`ICACHE_LINE_COUNT);

  logic [`ICACHE_COUNT_ALIGN:0] sweep_cnt_q;
  logic                         sweep;
  logic                         flush_fire;
  logic                         lookup_fire;

  // -----------------------------------------------------------------
  // Invalidation sweep
  // -----------------------------------------------------------------
  assign sweep      = sweep_cnt_q != sweep_end;
  assign flush_fire = flush_valid_i && flush_ready_o;

  // Starts at zero out of reset, restarts on an accepted flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sweep_cnt_q <= '0;
    end else if (sweep) begin
      sweep_cnt_q <= sweep_cnt_q + 1'b1;
    end else if (flush_fire) begin
      sweep_cnt_q <= '0;
    end
  end

  // Handshakes: sweep blocks all, a pending refill blocks lookups
  assign flush_ready_o = !sweep;
  assign write_ready_o = !sweep;
  assign in_ready_o    = !sweep && !write_valid_i && sel_ready_i;
  assign lookup_fire   = in_valid_i && in_ready_o;

  // -----------------------------------------------------------------
  // Array port arbitration
  // -----------------------------------------------------------------
  always_comb begin
    port_o       = '0;
    tag_wdata_o  = '0;
    line_wdata_o = '0;
    if (sweep) begin
      // Clear this index in every set
      port_o.wmask = '1;
      port_o.index = sweep_cnt_q[`ICACHE_COUNT_ALIGN-1:0];
    end else if (write_valid_i) begin
      port_o.wmask[write_i.cset] = 1'b1;
      port_o.index               = write_i.index;
      tag_wdata_o.valid          = 1'b1;
      tag_wdata_o.error          = write_i.error;
      tag_wdata_o.tag            = write_i.tag;
      line_wdata_o               = write_i.line;
    end else begin
      port_o.re    = lookup_fire;
      port_o.index = in_req_i.addr[`ICACHE_LINE_ALIGN +: `ICACHE_COUNT_ALIGN];
    end
  end

  // -----------------------------------------------------------------
  // Lookup launch
  // -----------------------------------------------------------------
  // Arrays return data the cycle after the read, so does launch
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      launch_o <= 1'b0;
    end else begin
      launch_o <= lookup_fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_fire) begin
      launch_req_o <= in_req_i;
    end
  end

endmodule

//--- design/hit_select.sv
// -------------------------------------------------------------------
// Hit selector
// Tag compare, lowest-set pick, line mux and fall-through buffer
// -------------------------------------------------------------------

`timescale 1ns/1ps

`include "icache_params.svh"

module hit_select (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  icache_pkg::tag_entry_t [`ICACHE_SET_COUNT-1:0] tags_i,
  input  icache_pkg::line_t [`ICACHE_SET_COUNT-1:0]      lines_i,
  input  logic                                          launch_i,
  input  icache_pkg::fetch_req_t                        launch_req_i,
  output logic                                          ready_o,
  output icache_pkg::lookup_rsp_t                       out_rsp_o,
  input  logic                                          out_ready_i,
  output logic                                          out_valid_o
);

  import icache_pkg::*;

  logic [`ICACHE_TAG_WIDTH-1:0] req_tag;
  logic [`ICACHE_SET_COUNT-1:0] set_hit;
  lookup_rsp_t                  rsp_s;
  lookup_rsp_t                  rsp_q;
  logic                         buf_valid_q;
  logic                         pend_q;
  logic                         live;

  // -----------------------------------------------------------------
  // Tag compare and set selection
  // -----------------------------------------------------------------
  assign req_tag = launch_req_i.addr[`ICACHE_FETCH_AW-1 -: `ICACHE_TAG_WIDTH];

  always_comb begin
    rsp_s      = '0;
    rsp_s.addr = launch_req_i.addr;
    rsp_s.id   = launch_req_i.id;
    for (int s = 0; s < `ICACHE_SET_COUNT; s++) begin
      set_hit[s] = tags_i[s].valid && (tags_i[s].tag == req_tag);
    end
    // Walk down so the lowest hitting set is the last one taken
    for (int s = `ICACHE_SET_COUNT - 1; s >= 0; s--) begin
      if (set_hit[s]) begin
        rsp_s.hit   = 1'b1;
        rsp_s.cset  = `ICACHE_SET_ALIGN'(s);
        rsp_s.error = tags_i[s].error;
        rsp_s.line  = lines_i[s];
      end
    end
  end

  // -----------------------------------------------------------------
  // Fall-through output buffer
  // -----------------------------------------------------------------
  // A fresh result sits on the array outputs until it moves on
  assign live        = launch_i || pend_q;
  assign out_valid_o = buf_valid_q || live;
  assign out_rsp_o   = buf_valid_q ? rsp_q : rsp_s;
  assign ready_o     = !buf_valid_q || out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_valid_q <= 1'b0;
      pend_q      <= 1'b0;
    end else if (buf_valid_q) begin
      // Buffered response is older, it goes out first
      if (out_ready_i) begin
        buf_valid_q <= live;
        pend_q      <= 1'b0;
      end else begin
        pend_q      <= live;
      end
    end else begin
      buf_valid_q <= live && !out_ready_i;
      pend_q      <= 1'b0;
    end
  end

  // Capture when the live result cannot leave this cycle
  always_ff @(posedge clk_i) begin
    if (live && (buf_valid_q ? out_ready_i : !out_ready_i)) begin
      rsp_q <= rsp_s;
    end
  end

endmodule

//--- design/icache_lookup.sv
// -------------------------------------------------------------------
// Instruction cache lookup top level
// Controller, tag and data way arrays, hit selector
// -------------------------------------------------------------------

`timescale 1ns/1ps

`include "icache_params.svh"

module icache_lookup (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  icache_pkg::fetch_req_t  in_req_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  output icache_pkg::lookup_rsp_t out_rsp_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  input  icache_pkg::refill_t     write_i,
  input  logic                    write_valid_i,
  output logic                    write_ready_o,
  input  logic                    flush_valid_i,
  output logic                    flush_ready_o
);

  import icache_pkg::*;

  array_port_t                         port;
  tag_entry_t                          tag_wdata;
  line_t                               line_wdata;
  tag_entry_t [`ICACHE_SET_COUNT-1:0]  tags;
  line_t [`ICACHE_SET_COUNT-1:0]       lines;
  logic                                launch;
  fetch_req_t                          launch_req;
  logic                                sel_ready;

  lookup_ctrl u_lookup_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .in_req_i      (in_req_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .write_i       (write_i),
    .write_valid_i (write_valid_i),
    .write_ready_o (write_ready_o),
    .flush_valid_i (flush_valid_i),
    .flush_ready_o (flush_ready_o),
    .sel_ready_i   (sel_ready),
    .port_o        (port),
    .tag_wdata_o   (tag_wdata),
    .line_wdata_o  (line_wdata),
    .launch_o      (launch),
    .launch_req_o  (launch_req)
  );

  // Tag and data stores share one command port
  way_array #(.payload_t(tag_entry_t)) u_tag_array (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .port_i  (port),
    .wdata_i (tag_wdata),
    .rdata_o (tags)
  );

  way_array #(.payload_t(line_t)) u_data_array (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .port_i  (port),
    .wdata_i (line_wdata),
    .rdata_o (lines)
  );

  hit_select u_hit_select (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .tags_i       (tags),
    .lines_i      (lines),
    .launch_i     (launch),
    .launch_req_i (launch_req),
    .ready_o      (sel_ready),
    .out_rsp_o    (out_rsp_o),
    .out_ready_i  (out_ready_i),
    .out_valid_o  (out_valid_o)
  );

endmodule

//--- dv/icache_lookup_properties.sv
// -------------------------------------------------------------------
// Lookup handshake properties
// Output stability, sweep blocking and ready outputs out of reset
// -------------------------------------------------------------------

`timescale 1ns/1ps

module icache_lookup_properties (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    in_ready_o,
  input icache_pkg::lookup_rsp_t out_rsp_o,
  input logic                    out_valid_o,
  input logic                    out_ready_i,
  input logic                    write_valid_i,
  input logic                    write_ready_o,
  input logic                    flush_ready_o
);

  // A stalled response holds until it is taken
  rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> $stable(out_rsp_o))
    else $error("out_rsp_o changed while stalled");

  // write_ready_o is low exactly while the sweep runs
  sweep_block: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !write_ready_o |-> !in_ready_o)
    else $error("in_ready_o high during the invalidation sweep");

  reset_ready: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !in_ready_o && !write_ready_o && !flush_ready_o)
    else $error("ready output high in the first cycle after reset");

  refill_block: assert property (@(posedge clk_i) disable iff (!rst_ni)
    write_valid_i |-> !in_ready_o)
    else $error("in_ready_o high while a refill is pending");

endmodule

bind icache_lookup icache_lookup_properties u_icache_lookup_properties (.*);

//--- dv/tb_icache_lookup.sv
// -------------------------------------------------------------------
// Instruction cache lookup testbench
// Random refills, lookups and flushes checked against a reference model
// -------------------------------------------------------------------

`timescale 1ns/1ps

`include "icache_params.svh"

module tb_icache_lookup;

  import icache_pkg::*;

  localparam int num_req    = 400;
  localparam int max_flush  = 3;
  // Lookups are offered about every other cycle
  localparam int req_cycles = 2 * num_req;
  localparam int cycle_limit = 4 * req_cycles + (max_flush + 1) * `ICACHE_LINE_COUNT;
  localparam logic [`ICACHE_TAG_WIDTH-1:0] tag_base = `ICACHE_TAG_WIDTH'('hA5C300);

  logic        clk_i;
  logic        rst_ni;
  fetch_req_t  in_req_i;
  logic        in_valid_i;
  logic        in_ready_o;
  lookup_rsp_t out_rsp_o;
  logic        out_valid_o;
  logic        out_ready_i;
  refill_t     write_i;
  logic        write_valid_i;
  logic        write_ready_o;
  logic        flush_valid_i;
  logic        flush_ready_o;

  // Reference copy of both arrays
  tag_entry_t  model_tag [`ICACHE_SET_COUNT][`ICACHE_LINE_COUNT];
  line_t       model_line [`ICACHE_SET_COUNT][`ICACHE_LINE_COUNT];
  lookup_rsp_t exp_q [$];

  logic [31:0] rng;
  logic        in_fire;
  logic        wr_fire;
  logic        fl_fire;
  logic        alone_q;
  int          cycles;
  int          errors;
  int          checks;
  int          sent;
  int          done;
  int          flushes;
  int          sweep_left;

  icache_lookup u_icache_lookup (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Small tag pool so refilled lines get hit again
  function automatic logic [`ICACHE_TAG_WIDTH-1:0] pick_tag(logic [1:0] sel);
    return tag_base ^ `ICACHE_TAG_WIDTH'(sel);
  endfunction

  // Lowest valid set with a matching tag supplies line and error
  function automatic lookup_rsp_t predict_rsp(fetch_req_t req);
    lookup_rsp_t                    rsp;
    logic [`ICACHE_COUNT_ALIGN-1:0] idx;
    rsp      = '0;
    rsp.addr = req.addr;
    rsp.id   = req.id;
    idx      = req.addr[`ICACHE_LINE_ALIGN +: `ICACHE_COUNT_ALIGN];
    for (int s = 0; s < `ICACHE_SET_COUNT; s++) begin
      if (!rsp.hit && model_tag[s][idx].valid &&
          model_tag[s][idx].tag == req.addr[`ICACHE_FETCH_AW-1 -: `ICACHE_TAG_WIDTH]) begin
        rsp.hit   = 1'b1;
        rsp.cset  = `ICACHE_SET_ALIGN'(s);
        rsp.error = model_tag[s][idx].error;
        rsp.line  = model_line[s][idx];
      end
    end
    return rsp;
  endfunction

  task automatic clear_model();
    for (int s = 0; s < `ICACHE_SET_COUNT; s++) begin
      for (int i = 0; i < `ICACHE_LINE_COUNT; i++) begin
        model_tag[s][i]  = '0;
        model_line[s][i] = '0;
      end
    end
  endtask

  // -----------------------------------------------------------------
  // Sampling at the falling edge where all outputs have settled
  // -----------------------------------------------------------------
  task automatic check_cycle();
    lookup_rsp_t want;
    logic        sweeping;
    cycles++;
    in_fire = in_valid_i && in_ready_o;
    wr_fire = write_valid_i && write_ready_o;
    fl_fire = flush_valid_i && flush_ready_o;
    // Sweep expected after reset release and after each accepted flush
    sweeping = sweep_left != 0;
    checks++;
    assert (write_ready_o == !sweeping && flush_ready_o == !sweeping) else begin
      $display("[ERROR] sweep_ready: expected write %b flush %b actual write %b flush %b",
               !sweeping, !sweeping, write_ready_o, flush_ready_o);
      errors++;
    end
    if (sweeping) begin
      sweep_left--;
      assert (!in_ready_o) else begin
        $display("[ERROR] sweep_block: expected 0 actual %b", in_ready_o);
        errors++;
      end
    end
    if (alone_q) begin
      assert (out_valid_o) else begin
        $display("Lookup accepted in the previous cycle was not presented on the output");
        errors++;
      end
    end
    if (out_valid_o && out_ready_i) begin
      checks++;
      done++;
      assert (exp_q.size() != 0) else begin
        $display("Response delivered while no lookup was outstanding");
        errors++;
      end
      if (exp_q.size() != 0) begin
        want = exp_q.pop_front();
        assert (out_rsp_o == want) else begin
          $display("[ERROR] lookup_response: expected %h actual %h", want, out_rsp_o);
          errors++;
        end
      end
    end
    if (in_fire) begin
      exp_q.push_back(predict_rsp(in_req_i));
    end
    alone_q = in_fire && exp_q.size() == 1;
    if (wr_fire) begin
      model_tag[write_i.cset][write_i.index] =
        '{valid: 1'b1, error: write_i.error, tag: write_i.tag};
      model_line[write_i.cset][write_i.index] = write_i.line;
    end
    // A flush sweep follows any refill taken in the same cycle
    if (fl_fire) begin
      clear_model();
      flushes++;
      sweep_left = `ICACHE_LINE_COUNT;
    end
  endtask

  // New values only once the previous transfer has happened
  task automatic drive_cycle();
    logic [31:0] ctl;
    rng         = xorshift32(rng);
    ctl         = rng;
    out_ready_i = ctl[1:0] != 2'b00;
    if (!write_valid_i || wr_fire) begin
      write_valid_i = ctl[3:2] == 2'b00;
      for (int w = 0; w < 4; w++) begin
        rng                    = xorshift32(rng);
        write_i.line[32*w +: 32] = rng;
      end
      rng           = xorshift32(rng);
      write_i.index = rng[7:4];
      write_i.cset  = rng[8];
      write_i.tag   = pick_tag(rng[10:9]);
      write_i.error = rng[11];
    end
    if (!in_valid_i || in_fire) begin
      in_valid_i = ctl[4] && sent < num_req;
      rng        = xorshift32(rng);
      in_req_i.addr = {pick_tag(rng[10:9]), rng[7:4], rng[3:0]};
      in_req_i.id   = sent[`ICACHE_ID_WIDTH-1:0];
      if (in_valid_i) begin
        sent++;
      end
    end
    if (!flush_valid_i || fl_fire) begin
      flush_valid_i = ctl[11:6] == 6'd0 && flushes < max_flush;
    end
  endtask

  initial begin
    rng           = 32'd4;
    alone_q       = 1'b0;
    sweep_left    = 0;
    in_req_i      = '0;
    in_valid_i    = 1'b0;
    out_ready_i   = 1'b0;
    write_i       = '0;
    write_valid_i = 1'b0;
    flush_valid_i = 1'b0;
    rst_ni        = 1'b0;
    clear_model();
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    sweep_left = `ICACHE_LINE_COUNT;
    while (done < num_req && cycles < cycle_limit) begin
      @(negedge clk_i);
      check_cycle();
      @(posedge clk_i);
      #1;
      drive_cycle();
    end
    if (done < num_req) begin
      $display("Timeout: only %0d of %0d responses after %0d cycles", done, num_req, cycles);
      errors++;
    end
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+design
design/icache_pkg.sv
design/way_array.sv
design/lookup_ctrl.sv
design/hit_select.sv
design/icache_lookup.sv
dv/icache_lookup_properties.sv
dv/tb_icache_lookup.sv

//--- Makefile
# Verilator build and run for the instruction cache lookup

VERILATOR ?= verilator
TOP       ?= tb_icache_lookup
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
